//--- gb_io_pkg.sv
// shared types, register offsets and LCD timing for the 0xFF00 page
// one dot per cpu_clock cycle, mode 3 fixed at 172 dots (no sprite stretch)
package gb_io_pkg;

	// ------------------------------------------------------------
	// types with a meaning of their own
	// ------------------------------------------------------------
	typedef logic [7:0]  io_addr_t;	// offset within 0xFF00 page
	typedef logic [7:0]  io_data_t;	// one register byte
	typedef logic [15:0] div_count_t;	// free running divider
	typedef logic [8:0]  dot_t;	// dot within a line, 0..455
	typedef logic [7:0]  line_t;	// LY, 0..153

	// STAT mode field encoding
	typedef enum logic [1:0] {
		mode_hblank   = 2'd0,
		mode_vblank   = 2'd1,
		mode_oam      = 2'd2,
		mode_transfer = 2'd3
	} lcd_mode_t;

	// ------------------------------------------------------------
	// register offsets
	// ------------------------------------------------------------
	localparam io_addr_t addr_div  = 8'h04;
	localparam io_addr_t addr_tima = 8'h05;
	localparam io_addr_t addr_tma  = 8'h06;
	localparam io_addr_t addr_tac  = 8'h07;
	localparam io_addr_t addr_lcdc = 8'h40;
	localparam io_addr_t addr_stat = 8'h41;
	localparam io_addr_t addr_ly   = 8'h44;
	localparam io_addr_t addr_lyc  = 8'h45;

	// ------------------------------------------------------------
	// line and frame timing, in dots and lines
	// ------------------------------------------------------------
	localparam dot_t  dots_per_line   = 9'd456;
	localparam dot_t  oam_dots        = 9'd80;
	localparam dot_t  transfer_dots   = 9'd172;
	localparam line_t visible_lines   = 8'd144;
	localparam line_t lines_per_frame = 8'd154;

	// reset and read values
	localparam io_data_t tac_reset     = 8'hF8;	// upper bits read as 1
	localparam io_data_t unmapped_read = 8'hFF;	// open bus

endpackage

//--- periph_bus_if.sv
// register access from the Wishbone bridge to one register block
// sel is a single-cycle strobe, rdata is combinational from the block
`timescale 1ns/1ps

interface periph_bus_if;
	logic                 sel;	// one cycle per access
	logic                 we;
	logic [1:0]           offset;	// register index inside the block
	gb_io_pkg::io_data_t  wdata;
	gb_io_pkg::io_data_t  rdata;

	modport bridge (
		output sel,
		output we,
		output offset,
		output wdata,
		input  rdata
	);

	modport block (
		input  sel,
		input  we,
		input  offset,
		input  wdata,
		output rdata
	);
endinterface

//--- wb_reg_bridge.sv
// Wishbone classic slave for the 0xFF00 page, one wait cycle per access
// master must hold the request until ack; no retry or error
`timescale 1ns/1ps

module wb_reg_bridge (
	input  logic                 cpu_clock,
	input  logic                 rst,
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  gb_io_pkg::io_addr_t  wb_adr,
	input  gb_io_pkg::io_data_t  wb_wdata,
	output gb_io_pkg::io_data_t  wb_rdata,
	output logic                 wb_ack,
	periph_bus_if.bridge         timer_bus,
	periph_bus_if.bridge         line_bus,
	periph_bus_if.bridge         stat_bus
);
	logic req;
	logic hit_timer;
	logic hit_line;
	logic hit_stat;
	gb_io_pkg::io_data_t rd_next;

	// new request only while no ack is out, so one strobe per access
	assign req = wb_cyc & wb_stb & ~wb_ack;

	// ------------------------------------------------------------
	// block decode
	// ------------------------------------------------------------
	assign hit_timer = wb_adr[7:2] == gb_io_pkg::addr_div[7:2];	// 0x04..0x07
	assign hit_line  = wb_adr == gb_io_pkg::addr_lcdc || wb_adr == gb_io_pkg::addr_ly;
	assign hit_stat  = wb_adr == gb_io_pkg::addr_stat || wb_adr == gb_io_pkg::addr_lyc;

	assign timer_bus.sel    = req & hit_timer;
	assign timer_bus.we     = wb_we;
	assign timer_bus.wdata  = wb_wdata;
	assign timer_bus.offset = wb_adr[1:0];

	// LCD registers pair up 4 apart, so bits 3:2 pick the register
	assign line_bus.sel    = req & hit_line;
	assign line_bus.we     = wb_we;
	assign line_bus.wdata  = wb_wdata;
	assign line_bus.offset = wb_adr[3:2];

	assign stat_bus.sel    = req & hit_stat;
	assign stat_bus.we     = wb_we;
	assign stat_bus.wdata  = wb_wdata;
	assign stat_bus.offset = wb_adr[3:2];

	always_comb begin
		rd_next = gb_io_pkg::unmapped_read;
		if (hit_timer)
			rd_next = timer_bus.rdata;
		else if (hit_line)
			rd_next = line_bus.rdata;
		else if (hit_stat)
			rd_next = stat_bus.rdata;
	end

	always_ff @(posedge cpu_clock) begin
		if (rst)
			wb_ack <= 1'b0;
		else
			wb_ack <= req;	// high for exactly one cycle
	end

	always_ff @(posedge cpu_clock) begin
		if (req)
			wb_rdata <= rd_next;	// held through the ack cycle
	end

endmodule

//--- div_timer.sv
// DIV, TIMA, TMA and TAC; DIV counts every cpu_clock cycle
// TIMA counts falling edges of the tapped DIV bit, so a DIV write can tick it
`timescale 1ns/1ps

module div_timer (
	input  logic          cpu_clock,
	input  logic          rst,
	periph_bus_if.block   bus,
	output logic          irq_timer
);
	gb_io_pkg::div_count_t div_cnt;
	gb_io_pkg::io_data_t   tima;
	gb_io_pkg::io_data_t   tma;
	logic [2:0]            tac;	// enable, select[1:0]
	logic                  tap_bit;
	logic                  tap_prev;
	logic                  tick;
	logic                  wr;
	logic                  wr_div;
	logic                  wr_tima;
	logic                  wr_tma;
	logic                  wr_tac;

	assign wr      = bus.sel & bus.we;
	assign wr_div  = wr && bus.offset == gb_io_pkg::addr_div[1:0];
	assign wr_tima = wr && bus.offset == gb_io_pkg::addr_tima[1:0];
	assign wr_tma  = wr && bus.offset == gb_io_pkg::addr_tma[1:0];
	assign wr_tac  = wr && bus.offset == gb_io_pkg::addr_tac[1:0];

	// ------------------------------------------------------------
	// divider tap, 1024 / 16 / 64 / 256 cycles per tick
	// ------------------------------------------------------------
	always_comb begin
		case (tac[1:0])
			2'd0: tap_bit = div_cnt[9];
			2'd1: tap_bit = div_cnt[3];
			2'd2: tap_bit = div_cnt[5];
			default: tap_bit = div_cnt[7];
		endcase
	end

	assign tick = tac[2] & tap_prev & ~tap_bit;	// falling edge

	always_ff @(posedge cpu_clock) begin
		if (rst) begin
			div_cnt   <= '0;
			tima      <= '0;
			tma       <= '0;
			tac       <= gb_io_pkg::tac_reset[2:0];
			tap_prev  <= 1'b0;
			irq_timer <= 1'b0;
		end else begin
			div_cnt   <= wr_div ? '0 : div_cnt + 1'b1;
			tap_prev  <= tap_bit;
			irq_timer <= 1'b0;

			// a CPU write to TIMA wins over a tick in the same cycle
			if (wr_tima) begin
				tima <= bus.wdata;
			end else if (tick) begin
				if (tima == 8'hFF) begin
					tima      <= tma;	// reload on wrap
					irq_timer <= 1'b1;
				end else begin
					tima <= tima + 1'b1;
				end
			end

			if (wr_tma)
				tma <= bus.wdata;
			if (wr_tac)
				tac <= bus.wdata[2:0];
		end
	end

	// read mux
	always_comb begin
		case (bus.offset)
			gb_io_pkg::addr_div[1:0]:  bus.rdata = div_cnt[15:8];
			gb_io_pkg::addr_tima[1:0]: bus.rdata = tima;
			gb_io_pkg::addr_tma[1:0]:  bus.rdata = tma;
			default:                   bus.rdata = {5'b11111, tac};
		endcase
	end

endmodule

//--- lcd_line_timer.sv
// LCDC plus the dot and LY counters; mode is registered in step with them
// display off holds dot and LY at 0, enabling restarts at line 0 in OAM mode
`timescale 1ns/1ps

module lcd_line_timer (
	input  logic                  cpu_clock,
	input  logic                  rst,
	periph_bus_if.block           bus,
	output gb_io_pkg::line_t      ly,
	output gb_io_pkg::lcd_mode_t  mode,
	output logic                  lcd_on
);
	gb_io_pkg::io_data_t lcdc;
	gb_io_pkg::io_data_t lcdc_next;
	gb_io_pkg::dot_t     dot_cnt;
	gb_io_pkg::dot_t     dot_next;
	gb_io_pkg::line_t    ly_next;
	logic                wr_lcdc;

	// mode for a given position while the display runs
	function automatic gb_io_pkg::lcd_mode_t mode_at(input gb_io_pkg::dot_t d,
			input gb_io_pkg::line_t l);
		if (l >= gb_io_pkg::visible_lines)
			return gb_io_pkg::mode_vblank;
		if (d < gb_io_pkg::oam_dots)
			return gb_io_pkg::mode_oam;
		if (d < gb_io_pkg::dot_t'(gb_io_pkg::oam_dots + gb_io_pkg::transfer_dots))
			return gb_io_pkg::mode_transfer;
		return gb_io_pkg::mode_hblank;
	endfunction

	assign wr_lcdc = bus.sel && bus.we && bus.offset == gb_io_pkg::addr_lcdc[3:2];
	assign lcd_on  = lcdc[7];

	// ------------------------------------------------------------
	// next position
	// ------------------------------------------------------------
	always_comb begin
		lcdc_next = wr_lcdc ? bus.wdata : lcdc;
		dot_next  = '0;
		ly_next   = '0;
		if (lcdc_next[7] && lcdc[7]) begin	// running, not just switched on
			if (dot_cnt == gb_io_pkg::dots_per_line - 9'd1) begin
				dot_next = '0;
				if (ly != gb_io_pkg::lines_per_frame - 8'd1)
					ly_next = ly + 8'd1;
			end else begin
				dot_next = dot_cnt + 9'd1;
				ly_next  = ly;
			end
		end
	end

	always_ff @(posedge cpu_clock) begin
		if (rst) begin
			lcdc    <= '0;
			dot_cnt <= '0;
			ly      <= '0;
			mode    <= gb_io_pkg::mode_hblank;
		end else begin
			lcdc    <= lcdc_next;
			dot_cnt <= dot_next;
			ly      <= ly_next;
			mode    <= lcdc_next[7] ? mode_at(dot_next, ly_next) : gb_io_pkg::mode_hblank;
		end
	end

	// LY is read only, writes fall through
	always_comb begin
		case (bus.offset)
			gb_io_pkg::addr_lcdc[3:2]: bus.rdata = lcdc;
			gb_io_pkg::addr_ly[3:2]:   bus.rdata = ly;
			default:                   bus.rdata = gb_io_pkg::unmapped_read;
		endcase
	end

endmodule

//--- lcd_stat_irq.sv
// LYC, STAT enables, coincidence and the STAT / vblank interrupt pulses
// irq_stat fires on the rising edge of the OR of enabled sources only
`timescale 1ns/1ps

module lcd_stat_irq (
	input  logic                  cpu_clock,
	input  logic                  rst,
	periph_bus_if.block           bus,
	input  gb_io_pkg::line_t      ly,
	input  gb_io_pkg::lcd_mode_t  mode,
	input  logic                  lcd_on,
	output logic                  irq_stat,
	output logic                  irq_vblank
);
	gb_io_pkg::line_t lyc;
	logic [3:0]       stat_en;	// STAT bits 6:3
	logic             coinc;
	logic             stat_cond;
	logic             cond_prev;
	logic             vblank_prev;
	logic             wr;

	assign wr = bus.sel & bus.we;

	assign coinc = lcd_on && ly == lyc;	// reads 0 while off

	// ------------------------------------------------------------
	// combined STAT source, gated while the display is off
	// ------------------------------------------------------------
	assign stat_cond = lcd_on & (
		(stat_en[0] & (mode == gb_io_pkg::mode_hblank)) |
		(stat_en[1] & (mode == gb_io_pkg::mode_vblank)) |
		(stat_en[2] & (mode == gb_io_pkg::mode_oam)) |
		(stat_en[3] & coinc));

	assign irq_stat   = stat_cond & ~cond_prev;
	assign irq_vblank = (mode == gb_io_pkg::mode_vblank) & ~vblank_prev;	// first vblank cycle

	always_ff @(posedge cpu_clock) begin
		if (rst) begin
			lyc         <= '0;
			stat_en     <= '0;
			cond_prev   <= 1'b0;
			vblank_prev <= 1'b0;
		end else begin
			cond_prev   <= stat_cond;
			vblank_prev <= mode == gb_io_pkg::mode_vblank;
			if (wr && bus.offset == gb_io_pkg::addr_stat[3:2])
				stat_en <= bus.wdata[6:3];
			if (wr && bus.offset == gb_io_pkg::addr_lyc[3:2])
				lyc <= bus.wdata;
		end
	end

	always_comb begin
		case (bus.offset)
			gb_io_pkg::addr_stat[3:2]: bus.rdata = {1'b1, stat_en, coinc, mode};
			gb_io_pkg::addr_lyc[3:2]:  bus.rdata = lyc;
			default:                   bus.rdata = gb_io_pkg::unmapped_read;
		endcase
	end

endmodule

//--- gb_lcd_timer_top.sv
// divider/timer and LCD line timing behind one Wishbone slave port
// all logic on cpu_clock, one LCD dot per cycle
`timescale 1ns/1ps

module gb_lcd_timer_top (
	input  logic                  cpu_clock,
	input  logic                  rst,
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  gb_io_pkg::io_addr_t   wb_adr,
	input  gb_io_pkg::io_data_t   wb_wdata,
	output gb_io_pkg::io_data_t   wb_rdata,
	output logic                  wb_ack,
	output logic                  irq_vblank,
	output logic                  irq_stat,
	output logic                  irq_timer,
	output gb_io_pkg::lcd_mode_t  lcd_mode
);
	gb_io_pkg::line_t ly;
	logic             lcd_on;

	// ------------------------------------------------------------
	// register buses, one per block
	// ------------------------------------------------------------
	periph_bus_if timer_bus ();
	periph_bus_if line_bus ();
	periph_bus_if stat_bus ();

	wb_reg_bridge i_wb_reg_bridge (
		.cpu_clock (cpu_clock),
		.rst       (rst),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_wdata  (wb_wdata),
		.wb_rdata  (wb_rdata),
		.wb_ack    (wb_ack),
		.timer_bus (timer_bus.bridge),
		.line_bus  (line_bus.bridge),
		.stat_bus  (stat_bus.bridge)
	);

	div_timer i_div_timer (
		.cpu_clock (cpu_clock),
		.rst       (rst),
		.bus       (timer_bus.block),
		.irq_timer (irq_timer)
	);

	lcd_line_timer i_lcd_line_timer (
		.cpu_clock (cpu_clock),
		.rst       (rst),
		.bus       (line_bus.block),
		.ly        (ly),
		.mode      (lcd_mode),
		.lcd_on    (lcd_on)
	);

	lcd_stat_irq i_lcd_stat_irq (
		.cpu_clock  (cpu_clock),
		.rst        (rst),
		.bus        (stat_bus.block),
		.ly         (ly),
		.mode       (lcd_mode),
		.lcd_on     (lcd_on),
		.irq_stat   (irq_stat),
		.irq_vblank (irq_vblank)
	);

endmodule

//--- gb_lcd_timer_sva.sv
// concurrent checks on gb_lcd_timer_top, attached by bind
// ly and lcd_on are internal nets of the top level, reached by name
`timescale 1ns/1ps

module gb_lcd_timer_sva (
	input logic                  cpu_clock,
	input logic                  rst,
	input logic                  wb_ack,
	input logic                  irq_vblank,
	input logic                  irq_stat,
	input logic                  irq_timer,
	input gb_io_pkg::lcd_mode_t  lcd_mode,
	input gb_io_pkg::line_t      ly,
	input logic                  lcd_on
);
	// ------------------------------------------------------------
	// bus and interrupt pulses
	// ------------------------------------------------------------
	ack_one_cycle: assert property (@(posedge cpu_clock) disable iff (rst)
		wb_ack |=> !wb_ack)
		else $error("wb_ack high two cycles in a row");

	vblank_pulse: assert property (@(posedge cpu_clock) disable iff (rst)
		irq_vblank |=> !irq_vblank)
		else $error("irq_vblank longer than one cycle");

	stat_pulse: assert property (@(posedge cpu_clock) disable iff (rst)
		irq_stat |=> !irq_stat)
		else $error("irq_stat longer than one cycle");

	timer_pulse: assert property (@(posedge cpu_clock) disable iff (rst)
		irq_timer |=> !irq_timer)
		else $error("irq_timer longer than one cycle");

	// lines 144 and up are vblank only
	mode_in_vblank: assert property (@(posedge cpu_clock) disable iff (rst)
		ly >= gb_io_pkg::visible_lines |->
			lcd_mode != gb_io_pkg::mode_oam && lcd_mode != gb_io_pkg::mode_transfer)
		else $error("oam or transfer mode on a vblank line");

	ly_zero_when_off: assert property (@(posedge cpu_clock) disable iff (rst)
		!lcd_on |-> ly == '0)
		else $error("LY not 0 with display off");

endmodule

bind gb_lcd_timer_top gb_lcd_timer_sva i_gb_lcd_timer_sva (
	.cpu_clock  (cpu_clock),
	.rst        (rst),
	.wb_ack     (wb_ack),
	.irq_vblank (irq_vblank),
	.irq_stat   (irq_stat),
	.irq_timer  (irq_timer),
	.lcd_mode   (lcd_mode),
	.ly         (ly),
	.lcd_on     (lcd_on)
);

//--- tb_gb_lcd_timer.sv
// testbench for gb_lcd_timer_top covering registers, timer period, DIV clear and frame timing
// inputs change on the falling edge and the run stops at the first failing check
`timescale 1ns/1ps

module tb_gb_lcd_timer;
	logic                 cpu_clock;
	logic                 rst;
	logic                 wb_cyc;
	logic                 wb_stb;
	logic                 wb_we;
	gb_io_pkg::io_addr_t  wb_adr;
	gb_io_pkg::io_data_t  wb_wdata;
	gb_io_pkg::io_data_t  wb_rdata;
	logic                 wb_ack;
	logic                 irq_vblank;
	logic                 irq_stat;
	logic                 irq_timer;
	gb_io_pkg::lcd_mode_t lcd_mode;

	integer      seed;
	int unsigned cycle_count = 0;	// stamps for pulse spacing

	initial cpu_clock = 1'b0;
	always #2 cpu_clock = ~cpu_clock;	// 4 ns period

	always @(posedge cpu_clock)
		cycle_count <= cycle_count + 1;

	gb_lcd_timer_top i_gb_lcd_timer_top (
		.cpu_clock  (cpu_clock),
		.rst        (rst),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_wdata   (wb_wdata),
		.wb_rdata   (wb_rdata),
		.wb_ack     (wb_ack),
		.irq_vblank (irq_vblank),
		.irq_stat   (irq_stat),
		.irq_timer  (irq_timer),
		.lcd_mode   (lcd_mode)
	);

	// ------------------------------------------------------------
	// expected values
	// ------------------------------------------------------------
	function automatic int ref_tima_period(input logic [1:0] sel, input gb_io_pkg::io_data_t tma);
		int per_tick;
		case (sel)
			2'd0: per_tick = 1024;
			2'd1: per_tick = 16;
			2'd2: per_tick = 64;
			default: per_tick = 256;
		endcase
		return per_tick * (256 - int'(tma));	// ticks from TMA up to the wrap
	endfunction

	function automatic gb_io_pkg::io_data_t ref_stat_read(input logic [3:0] enables,
			input logic coinc, input logic [1:0] mode);
		return {1'b1, enables, coinc, mode};
	endfunction

	// mode a given number of cycles after vblank entry (line 144, dot 0)
	function automatic logic [1:0] ref_mode_at(input int since_vblank);
		int pos;
		int line;
		int dot;
		pos  = (144 * 456 + since_vblank) % (456 * 154);
		line = pos / 456;
		dot  = pos % 456;
		if (line >= 144)
			return gb_io_pkg::mode_vblank;
		if (dot < 80)
			return gb_io_pkg::mode_oam;
		if (dot < 80 + 172)
			return gb_io_pkg::mode_transfer;
		return gb_io_pkg::mode_hblank;
	endfunction

	// ------------------------------------------------------------
	// checks and bus tasks
	// ------------------------------------------------------------
	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: %s did not happen in time", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped on timeout");
	endtask

	task automatic wb_write(input gb_io_pkg::io_addr_t adr, input gb_io_pkg::io_data_t data);
		int waited;
		waited   = 0;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_wdata = data;
		do begin
			@(negedge cpu_clock);
			waited++;
		end while (!wb_ack && waited < 16);
		if (!wb_ack) begin
			report_timeout("wb_ack on write");
		end else begin
			wb_cyc = 1'b0;
			wb_stb = 1'b0;
			wb_we  = 1'b0;
		end
	endtask

	task automatic wb_read(input gb_io_pkg::io_addr_t adr, output gb_io_pkg::io_data_t data);
		int waited;
		waited = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		do begin
			@(negedge cpu_clock);
			waited++;
		end while (!wb_ack && waited < 16);
		if (!wb_ack) begin
			report_timeout("wb_ack on read");
		end else begin
			data   = wb_rdata;	// valid while ack is high
			wb_cyc = 1'b0;
			wb_stb = 1'b0;
		end
	endtask

	// which selects 0 vblank, 1 stat, 2 timer
	task automatic wait_irq(input string name, input int which, input int limit,
			output int unsigned stamp);
		int   waited;
		logic seen;
		waited = 0;
		seen   = 1'b0;
		while (!seen && waited < limit) begin
			@(negedge cpu_clock);
			waited++;
			case (which)
				0: seen = irq_vblank;
				1: seen = irq_stat;
				default: seen = irq_timer;
			endcase
		end
		if (!seen)
			report_timeout(name);
		else
			stamp = cycle_count;
	endtask

	// ------------------------------------------------------------
	// stimulus and compare
	// ------------------------------------------------------------
	initial begin
		gb_io_pkg::io_data_t rd;
		gb_io_pkg::io_data_t tma_val;
		gb_io_pkg::line_t    lyc_val;
		int unsigned         t_first;
		int unsigned         t_second;
		int                  frame_cycles;
		int                  k;
		seed         = 32'hd80d;
		frame_cycles = 456 * 154;
		rst          = 1'b1;
		wb_cyc       = 1'b0;
		wb_stb       = 1'b0;
		wb_we        = 1'b0;
		wb_adr       = '0;
		wb_wdata     = '0;
		repeat (16) @(negedge cpu_clock);
		rst = 1'b0;
		@(negedge cpu_clock);

		// register reset values and read-back
		wb_read(gb_io_pkg::addr_tac, rd);
		check_value("tac after reset", 8'hF8, rd);
		wb_read(gb_io_pkg::addr_lcdc, rd);
		check_value("lcdc after reset", 8'h00, rd);
		wb_read(gb_io_pkg::addr_ly, rd);
		check_value("ly after reset", 8'h00, rd);
		wb_write(gb_io_pkg::addr_tma, 8'hA5);
		wb_read(gb_io_pkg::addr_tma, rd);
		check_value("tma read-back", 8'hA5, rd);
		wb_write(gb_io_pkg::addr_lyc, 8'h3C);
		wb_read(gb_io_pkg::addr_lyc, rd);
		check_value("lyc read-back", 8'h3C, rd);
		wb_write(gb_io_pkg::addr_lcdc, 8'h13);	// bit 7 clear so the display stays off
		wb_read(gb_io_pkg::addr_lcdc, rd);
		check_value("lcdc read-back", 8'h13, rd);
		wb_read(8'h00, rd);
		check_value("unmapped 0x00", 8'hFF, rd);
		wb_read(8'h42, rd);
		check_value("unmapped 0x42", 8'hFF, rd);
		wb_write(gb_io_pkg::addr_ly, 8'h55);
		wb_read(gb_io_pkg::addr_ly, rd);
		check_value("ly ignores writes", 8'h00, rd);

		// timer overflow period with select 1
		tma_val = 8'($random(seed));
		wb_write(gb_io_pkg::addr_tma, tma_val);
		wb_write(gb_io_pkg::addr_tac, 8'h05);
		wait_irq("first timer overflow", 2, 2 * 4096, t_first);
		wait_irq("second timer overflow", 2, ref_tima_period(2'd1, tma_val) + 64, t_second);
		check_value("timer overflow spacing", ref_tima_period(2'd1, tma_val), t_second - t_first);
		wb_read(gb_io_pkg::addr_tima, rd);
		check_value("tima at least tma after reload", 1, rd >= tma_val);
		wb_write(gb_io_pkg::addr_tac, 8'h00);

		// DIV clear and the upper byte counting every 256 cycles
		wb_write(gb_io_pkg::addr_div, 8'h5A);
		wb_read(gb_io_pkg::addr_div, rd);
		check_value("div right after clear", 8'h00, rd);
		repeat (510) @(negedge cpu_clock);
		wb_read(gb_io_pkg::addr_div, rd);
		check_value("div 512 cycles after clear", 8'h02, rd);

		// frame timing
		wb_write(gb_io_pkg::addr_lcdc, 8'h91);
		wait_irq("first vblank", 0, 2 * frame_cycles, t_first);
		for (k = 0; k < frame_cycles; k++) begin
			if (k > 0)
				@(negedge cpu_clock);
			check_value("lcd_mode over frame", ref_mode_at(k), lcd_mode);
		end
		wait_irq("second vblank", 0, 2 * frame_cycles, t_second);
		check_value("vblank spacing", frame_cycles, t_second - t_first);

		// STAT interrupt on LY == LYC only
		lyc_val = 8'($unsigned($random(seed)) % 144);
		wb_write(gb_io_pkg::addr_lyc, lyc_val);
		wb_write(gb_io_pkg::addr_stat, 8'h40);
		wait_irq("vblank before lyc match", 0, 2 * frame_cycles, t_first);
		wait_irq("lyc stat interrupt", 1, 2 * frame_cycles, t_first);
		wb_read(gb_io_pkg::addr_stat, rd);
		check_value("stat at lyc match", ref_stat_read(4'b1000, 1'b1, gb_io_pkg::mode_oam), rd);
		wb_read(gb_io_pkg::addr_ly, rd);
		check_value("ly at lyc match", lyc_val, rd);
		wait_irq("next lyc stat interrupt", 1, 2 * frame_cycles, t_second);
		check_value("stat interrupt spacing", frame_cycles, t_second - t_first);

		// display off
		wb_write(gb_io_pkg::addr_lcdc, 8'h11);
		check_value("lcd_mode with display off", gb_io_pkg::mode_hblank, lcd_mode);
		wb_read(gb_io_pkg::addr_ly, rd);
		check_value("ly with display off", 8'h00, rd);
		wb_write(gb_io_pkg::addr_lyc, 8'h00);	// LYC equals the held LY
		wb_read(gb_io_pkg::addr_stat, rd);
		check_value("stat with display off", ref_stat_read(4'b1000, 1'b0, gb_io_pkg::mode_hblank),
			rd);
		for (k = 0; k < frame_cycles + 456; k++) begin
			@(negedge cpu_clock);
			check_value("irq_vblank with display off", 0, irq_vblank);
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- compile.f
gb_io_pkg.sv
periph_bus_if.sv
wb_reg_bridge.sv
div_timer.sv
lcd_line_timer.sv
lcd_stat_irq.sv
gb_lcd_timer_top.sv
gb_lcd_timer_sva.sv
tb_gb_lcd_timer.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator from compile.f and runs it
# a failed build or a $fatal in the run gives a nonzero exit status
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_gb_lcd_timer \
	-f compile.f \
	&& ./obj_dir/Vtb_gb_lcd_timer \
	|| exit 1
